// ==== src/wb_mem_pkg.sv ====
package wb_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and memory sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int DW = 32;
  localparam int AW = 32;
  // One select line per byte lane
  localparam int SEL_W = DW / 8;
  // Byte offset bits below the word index
  localparam int ADR_LSB = 2;

  // 4 KiB of 32-bit words
  localparam int MEM_WORDS = 1024;
  localparam int WORD_ADR_W = 10;

  // Beat buffer depth, equal to the number of engine credits
  localparam int BEAT_FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = 2;
  // Counts 0 up to BEAT_FIFO_DEPTH inclusive
  localparam int CREDIT_W = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone cycle type and burst extension codes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [2:0] CTI_CLASSIC = 3'b000;
  localparam logic [2:0] CTI_CONST = 3'b001;
  localparam logic [2:0] CTI_INCR = 3'b010;
  localparam logic [2:0] CTI_EOB = 3'b111;

  localparam logic [1:0] BTE_LINEAR = 2'b00;
  localparam logic [1:0] BTE_WRAP4 = 2'b01;
  localparam logic [1:0] BTE_WRAP8 = 2'b10;
  localparam logic [1:0] BTE_WRAP16 = 2'b11;

  // Access engine states
  localparam logic [1:0] ENG_IDLE = 2'd0;
  localparam logic [1:0] ENG_STREAM = 2'd1;
  localparam logic [1:0] ENG_WAIT = 2'd2;

  // Memory word, whole for reads or split in byte lanes for masked writes
  typedef union packed {
    logic [DW-1:0] w;
    logic [SEL_W-1:0][7:0] b;
  } mem_word_u;

  // Address of the beat that follows adr in a burst
  function automatic logic [AW-1:0] next_burst_adr(
    input logic [AW-1:0] adr,
    input logic [2:0] cti,
    input logic [1:0] bte
  );
    logic [AW-1:0] wrap_mask;
    logic [AW-1:0] step_adr;
    // Bits allowed to change when the word index steps
    case (bte)
      BTE_WRAP4: wrap_mask = AW'((1 << (ADR_LSB + 2)) - 1);
      BTE_WRAP8: wrap_mask = AW'((1 << (ADR_LSB + 3)) - 1);
      BTE_WRAP16: wrap_mask = AW'((1 << (ADR_LSB + 4)) - 1);
      BTE_LINEAR: wrap_mask = '1;
      default: wrap_mask = '1;
    endcase
    step_adr = adr + AW'(SEL_W);
    // Constant, classic and end of burst keep the address
    if (cti == CTI_INCR) begin
      return (adr & ~wrap_mask) | (step_adr & wrap_mask);
    end
    return adr;
  endfunction

endpackage

// ==== src/burst_access_engine.sv ====
`timescale 1ns/100ps

module burst_access_engine
  import wb_mem_pkg::*;
(
  input  logic             wb_clk_i,
  input  logic             arst_n_i,
  // Live Wishbone request
  input  logic [AW-1:0]    wb_adr_i,
  input  logic [DW-1:0]    wb_dat_i,
  input  logic [SEL_W-1:0] wb_sel_i,
  input  logic             wb_we_i,
  input  logic [2:0]       wb_cti_i,
  input  logic [1:0]       wb_bte_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  // From the responder
  input  logic             credit_i,
  input  logic             flush_i,
  input  logic             beat_done_i,
  // Beat FIFO write side
  output logic             push_o,
  output logic [AW-1:0]    push_adr_o,
  output logic             push_we_o,
  output logic [DW-1:0]    push_dat_o,
  output logic             push_err_o
);

  //////////////////////////////////////////////////////////////////////////
  // Storage and state
  //////////////////////////////////////////////////////////////////////////

  mem_word_u mem [MEM_WORDS];

  logic [1:0]            state_q;
  logic [CREDIT_W-1:0]   credits_q;
  logic [CREDIT_W-1:0]   credits_nxt;

  // Request latched on entry to a transfer
  logic                  lat_we_q;
  logic [2:0]            lat_cti_q;
  logic [1:0]            lat_bte_q;
  mem_word_u             lat_dat_q;
  logic [SEL_W-1:0]      lat_sel_q;

  // Address of the next beat to fetch or write
  logic [AW-1:0]         cur_adr_q;
  logic [WORD_ADR_W-1:0] cur_idx;
  logic                  cur_oor;

  logic                  new_req;
  logic                  do_push;
  logic                  burst_cont;
  logic                  wait_done;

  //////////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////////

  // Only sampled when nothing is left in flight
  assign new_req = (state_q == ENG_IDLE) && wb_cyc_i && wb_stb_i;

  assign cur_idx = cur_adr_q[ADR_LSB +: WORD_ADR_W];
  // Word index past the end of the array
  assign cur_oor = cur_adr_q[AW-1:ADR_LSB] >= (AW - ADR_LSB)'(MEM_WORDS);

  // One beat per cycle while credits last
  assign do_push = (state_q == ENG_STREAM) && (credits_q != '0) && !flush_i;

  assign credits_nxt = credits_q - CREDIT_W'(do_push) + CREDIT_W'(credit_i);

  // Write waits for its own ack, read burst for all credits back
  assign wait_done = lat_we_q ? beat_done_i
                              : (credits_nxt == CREDIT_W'(BEAT_FIFO_DEPTH));

  // Prefetch goes on only for real bursts
  always_comb begin
    case (lat_cti_q)
      CTI_CONST, CTI_INCR: burst_cont = 1'b1;
      CTI_CLASSIC, CTI_EOB: burst_cont = 1'b0;
      default: burst_cont = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Control FSM and credits
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ENG_IDLE;
      credits_q <= CREDIT_W'(BEAT_FIFO_DEPTH);
      push_o    <= 1'b0;
      lat_we_q  <= 1'b0;
      lat_cti_q <= CTI_CLASSIC;
      lat_bte_q <= BTE_LINEAR;
    end else if (flush_i) begin
      // FIFO drops everything, so all credits come back at once
      state_q   <= ENG_IDLE;
      credits_q <= CREDIT_W'(BEAT_FIFO_DEPTH);
      push_o    <= 1'b0;
    end else begin
      push_o    <= do_push;
      credits_q <= credits_nxt;
      case (state_q)
        ENG_IDLE: begin
          if (new_req) begin
            state_q   <= ENG_STREAM;
            lat_we_q  <= wb_we_i;
            lat_cti_q <= wb_cti_i;
            lat_bte_q <= wb_bte_i;
          end
        end
        ENG_STREAM: begin
          // Single beats and writes stop after one push
          if (do_push && (lat_we_q || !burst_cont)) begin
            state_q <= ENG_WAIT;
          end
        end
        ENG_WAIT: begin
          if (wait_done) begin
            state_q <= ENG_IDLE;
          end
        end
        default: state_q <= ENG_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Address, write data and pushed entry
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (new_req) begin
      cur_adr_q   <= wb_adr_i;
      lat_dat_q.w <= wb_dat_i;
      lat_sel_q   <= wb_sel_i;
    end else if (do_push && !lat_we_q && burst_cont) begin
      // Predict the address the master asks for next
      cur_adr_q <= next_burst_adr(cur_adr_q, lat_cti_q, lat_bte_q);
    end
    if (do_push) begin
      push_adr_o <= cur_adr_q;
      push_we_o  <= lat_we_q;
      push_err_o <= cur_oor;
      // Old word for a write entry, never returned to the master
      push_dat_o <= mem[cur_idx].w;
    end
  end

  // Byte masked write, skipped for out of range beats
  always_ff @(posedge wb_clk_i) begin
    if (do_push && lat_we_q && !cur_oor) begin
      for (int i = 0; i < SEL_W; i++) begin
        if (lat_sel_q[i]) begin
          mem[cur_idx].b[i] <= lat_dat_q.b[i];
        end
      end
    end
  end

endmodule

// ==== src/beat_fifo.sv ====
`timescale 1ns/100ps

module beat_fifo
  import wb_mem_pkg::*;
(
  input  logic          wb_clk_i,
  input  logic          arst_n_i,
  // Write side from the engine
  input  logic          push_i,
  input  logic [AW-1:0] push_adr_i,
  input  logic          push_we_i,
  input  logic [DW-1:0] push_dat_i,
  input  logic          push_err_i,
  // Read side to the responder
  input  logic          pop_i,
  input  logic          flush_i,
  output logic          head_valid_o,
  output logic [AW-1:0] head_adr_o,
  output logic          head_we_o,
  output logic [DW-1:0] head_dat_o,
  output logic          head_err_o
);

  // Entry fields kept in parallel arrays
  logic [AW-1:0]         adr_mem [BEAT_FIFO_DEPTH];
  logic [DW-1:0]         dat_mem [BEAT_FIFO_DEPTH];
  logic                  we_mem  [BEAT_FIFO_DEPTH];
  logic                  err_mem [BEAT_FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [CREDIT_W-1:0]   count_q;

  logic                  do_push;
  logic                  do_pop;

  // Credits keep the engine from pushing into a full buffer
  assign do_push = push_i && !flush_i;
  assign do_pop  = pop_i && head_valid_o && !flush_i;

  // Pointers wrap on their own width
  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + FIFO_PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + FIFO_PTR_W'(1);
      end
      count_q <= count_q + CREDIT_W'(do_push) - CREDIT_W'(do_pop);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (do_push) begin
      adr_mem[wr_ptr_q] <= push_adr_i;
      dat_mem[wr_ptr_q] <= push_dat_i;
      we_mem[wr_ptr_q]  <= push_we_i;
      err_mem[wr_ptr_q] <= push_err_i;
    end
  end

  // Head straight from the storage flops
  assign head_valid_o = (count_q != '0);
  assign head_adr_o   = adr_mem[rd_ptr_q];
  assign head_dat_o   = dat_mem[rd_ptr_q];
  assign head_we_o    = we_mem[rd_ptr_q];
  assign head_err_o   = err_mem[rd_ptr_q];

endmodule

// ==== src/wb_beat_responder.sv ====
`timescale 1ns/100ps

module wb_beat_responder
  import wb_mem_pkg::*;
(
  // Live Wishbone beat
  input  logic [AW-1:0] wb_adr_i,
  input  logic          wb_we_i,
  input  logic          wb_cyc_i,
  input  logic          wb_stb_i,
  // Head of the beat FIFO
  input  logic          head_valid_i,
  input  logic [AW-1:0] head_adr_i,
  input  logic          head_we_i,
  input  logic [DW-1:0] head_dat_i,
  input  logic          head_err_i,
  input  logic          wb_clk_i,
  input  logic          arst_n_i,
  // Back to FIFO and engine
  output logic          pop_o,
  output logic          flush_o,
  output logic          credit_o,
  output logic          beat_done_o,
  // Wishbone response
  output logic          wb_ack_o,
  output logic          wb_err_o,
  output logic [DW-1:0] wb_dat_o
);

  //////////////////////////////////////////////////////////////////////////
  // Beat matching
  //////////////////////////////////////////////////////////////////////////

  logic live_beat;
  logic head_match;
  logic hit;
  logic mismatch;
  logic abandon;
  // Cycle open since its first beat
  logic active_q;

  assign live_beat = wb_cyc_i && wb_stb_i;

  // Prefetched entry must be exactly the beat the master asks for
  assign head_match = head_valid_i
                    && (head_adr_i == wb_adr_i)
                    && (head_we_i == wb_we_i);

  assign hit      = live_beat && head_match;
  // Prediction went wrong, refetch from the live beat
  assign mismatch = live_beat && head_valid_i && !head_match;
  // Master left the cycle with beats possibly still queued
  assign abandon  = !wb_cyc_i && (active_q || head_valid_i);

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
    end else begin
      active_q <= wb_cyc_i && (active_q || wb_stb_i);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Response and handshake
  //////////////////////////////////////////////////////////////////////////

  // Error entries answer with err instead of ack
  assign wb_ack_o = hit && !head_err_i;
  assign wb_err_o = hit && head_err_i;
  assign wb_dat_o = head_dat_i;

  // Each retired beat frees one slot
  assign pop_o    = hit;
  assign credit_o = hit;

  // Lets the engine take the next write beat
  assign beat_done_o = hit && head_we_i;

  assign flush_o = mismatch || abandon;

endmodule

// ==== src/wb_burst_mem.sv ====
`timescale 1ns/100ps

module wb_burst_mem
  import wb_mem_pkg::*;
(
  input  logic             wb_clk_i,
  input  logic             arst_n_i,
  input  logic [AW-1:0]    wb_adr_i,
  input  logic [DW-1:0]    wb_dat_i,
  input  logic [SEL_W-1:0] wb_sel_i,
  input  logic             wb_we_i,
  input  logic [2:0]       wb_cti_i,
  input  logic [1:0]       wb_bte_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  output logic             wb_ack_o,
  output logic             wb_err_o,
  output logic [DW-1:0]    wb_dat_o
);

  // Engine to FIFO
  logic          push;
  logic [AW-1:0] push_adr;
  logic          push_we;
  logic [DW-1:0] push_dat;
  logic          push_err;

  // FIFO head to responder
  logic          head_valid;
  logic [AW-1:0] head_adr;
  logic          head_we;
  logic [DW-1:0] head_dat;
  logic          head_err;

  // Responder feedback
  logic          pop;
  logic          flush;
  logic          credit;
  logic          beat_done;

  ////////////////////////////////////////////////////////////////////////////
  // Producer, buffer, consumer
  ////////////////////////////////////////////////////////////////////////////

  burst_access_engine u_engine (
    .wb_clk_i    (wb_clk_i),
    .arst_n_i    (arst_n_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_we_i     (wb_we_i),
    .wb_cti_i    (wb_cti_i),
    .wb_bte_i    (wb_bte_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .credit_i    (credit),
    .flush_i     (flush),
    .beat_done_i (beat_done),
    .push_o      (push),
    .push_adr_o  (push_adr),
    .push_we_o   (push_we),
    .push_dat_o  (push_dat),
    .push_err_o  (push_err)
  );

  beat_fifo u_fifo (
    .wb_clk_i     (wb_clk_i),
    .arst_n_i     (arst_n_i),
    .push_i       (push),
    .push_adr_i   (push_adr),
    .push_we_i    (push_we),
    .push_dat_i   (push_dat),
    .push_err_i   (push_err),
    .pop_i        (pop),
    .flush_i      (flush),
    .head_valid_o (head_valid),
    .head_adr_o   (head_adr),
    .head_we_o    (head_we),
    .head_dat_o   (head_dat),
    .head_err_o   (head_err)
  );

  wb_beat_responder u_responder (
    .wb_adr_i     (wb_adr_i),
    .wb_we_i      (wb_we_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .head_valid_i (head_valid),
    .head_adr_i   (head_adr),
    .head_we_i    (head_we),
    .head_dat_i   (head_dat),
    .head_err_i   (head_err),
    .wb_clk_i     (wb_clk_i),
    .arst_n_i     (arst_n_i),
    .pop_o        (pop),
    .flush_o      (flush),
    .credit_o     (credit),
    .beat_done_o  (beat_done),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .wb_dat_o     (wb_dat_o)
  );

endmodule

// ==== bench/wb_mem_checker.sv ====
`timescale 1ns/100ps

module wb_mem_checker
  import wb_mem_pkg::*;
(
  input  logic             wb_clk_i,
  input  logic             arst_n_i,
  // Request as seen on the bus
  input  logic [AW-1:0]    adr_i,
  input  logic [DW-1:0]    dat_w_i,
  input  logic [SEL_W-1:0] sel_i,
  input  logic             we_i,
  input  logic             cyc_i,
  input  logic             stb_i,
  // Slave response
  input  logic             ack_i,
  input  logic             err_i,
  input  logic [DW-1:0]    dat_r_i,
  // Running counts for the final report
  output int               read_cnt_o,
  output int               write_cnt_o,
  output int               err_resp_cnt_o,
  output int               error_cnt_o
);

  // Longest wait for one beat's response, in cycles
  localparam int BEAT_LIMIT = 32;

  // Reference memory, one entry per byte with a written flag
  logic [7:0] model_byte [MEM_WORDS*SEL_W];
  bit         written    [MEM_WORDS*SEL_W];
  int         pend_cycles;

  // Sampled mid cycle, request and response both settled
  always @(negedge wb_clk_i) begin : beat_check
    logic          in_range;
    logic          bad;
    logic [DW-1:0] exp_word;
    int            base;
    in_range = (adr_i >> ADR_LSB) < MEM_WORDS;
    base = int'(adr_i[ADR_LSB +: WORD_ADR_W]) * SEL_W;
    bad = 1'b0;
    if (!arst_n_i) begin
      read_cnt_o     = 0;
      write_cnt_o    = 0;
      err_resp_cnt_o = 0;
      error_cnt_o    = 0;
      pend_cycles    = 0;
    end else begin
      if (ack_i && err_i) begin
        $display("ack and err are both high for address %h", adr_i);
        error_cnt_o++;
      end
      if ((ack_i || err_i) && !(cyc_i && stb_i)) begin
        $display("Response given at %0t while no beat is requested", $time);
        error_cnt_o++;
      end
      if (cyc_i && stb_i && (ack_i || err_i)) begin
        pend_cycles = 0;
        if ((ack_i !== in_range) || (err_i !== !in_range)) begin
          // {ack, err}
          $display("[ERROR] response adr=%h expected=%b actual=%b",
                   adr_i, {in_range, !in_range}, {ack_i, err_i});
          error_cnt_o++;
        end else if (err_i) begin
          // Memory left as is
          err_resp_cnt_o++;
        end else if (we_i) begin
          for (int i = 0; i < SEL_W; i++) begin
            if (sel_i[i]) begin
              model_byte[base+i] = dat_w_i[8*i +: 8];
              written[base+i]    = 1'b1;
            end
          end
          write_cnt_o++;
        end else begin
          // Unwritten bytes hold no known value
          for (int i = 0; i < SEL_W; i++) begin
            if (written[base+i]) begin
              exp_word[8*i +: 8] = model_byte[base+i];
              if (dat_r_i[8*i +: 8] !== model_byte[base+i]) begin
                bad = 1'b1;
              end
            end else begin
              exp_word[8*i +: 8] = 8'hxx;
            end
          end
          if (bad) begin
            $display("[ERROR] read_data adr=%h expected=%h actual=%h",
                     adr_i, exp_word, dat_r_i);
            error_cnt_o++;
          end
          read_cnt_o++;
        end
      end else if (cyc_i && stb_i) begin
        pend_cycles++;
        if (pend_cycles == BEAT_LIMIT) begin
          $display("Beat at address %h got no ack or err within %0d cycles",
                   adr_i, BEAT_LIMIT);
          error_cnt_o++;
        end
      end else begin
        pend_cycles = 0;
      end
    end
  end

endmodule

// ==== bench/tb_wb_burst_mem.sv ====
`timescale 1ns/100ps

module tb_wb_burst_mem
  import wb_mem_pkg::*;
();

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 8;
  localparam int          N_TRANS      = 300;
  // Average cycle budget of one transaction
  localparam int          TRANS_CYCLES = 40;
  localparam int          CYCLE_LIMIT  = N_TRANS * TRANS_CYCLES;
  localparam logic [31:0] SEED         = 32'h068484dd;

  logic             wb_clk_i;
  logic             arst_n_i;
  logic [AW-1:0]    wb_adr_i;
  logic [DW-1:0]    wb_dat_i;
  logic [SEL_W-1:0] wb_sel_i;
  logic             wb_we_i;
  logic [2:0]       wb_cti_i;
  logic [1:0]       wb_bte_i;
  logic             wb_cyc_i;
  logic             wb_stb_i;
  logic             wb_ack_o;
  logic             wb_err_o;
  logic [DW-1:0]    wb_dat_o;

  logic [31:0]      lfsr_q;
  int               cycle_cnt = 0;
  int               read_cnt;
  int               write_cnt;
  int               err_resp_cnt;
  int               error_cnt;

  wb_burst_mem uut (
    .wb_clk_i (wb_clk_i),
    .arst_n_i (arst_n_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),
    .wb_cti_i (wb_cti_i),
    .wb_bte_i (wb_bte_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .wb_dat_o (wb_dat_o)
  );

  wb_mem_checker chk (
    .wb_clk_i       (wb_clk_i),
    .arst_n_i       (arst_n_i),
    .adr_i          (wb_adr_i),
    .dat_w_i        (wb_dat_i),
    .sel_i          (wb_sel_i),
    .we_i           (wb_we_i),
    .cyc_i          (wb_cyc_i),
    .stb_i          (wb_stb_i),
    .ack_i          (wb_ack_o),
    .err_i          (wb_err_o),
    .dat_r_i        (wb_dat_o),
    .read_cnt_o     (read_cnt),
    .write_cnt_o    (write_cnt),
    .err_resp_cnt_o (err_resp_cnt),
    .error_cnt_o    (error_cnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Clock, watchdog, random source
  ////////////////////////////////////////////////////////////////////////////

  initial begin : clock_gen
    wb_clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin : watchdog
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout, run still busy after %0d cycles", cycle_cnt);
      report_counts();
      $display("TEST FAIL");
      $finish;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic report_counts();
    $display("Beats checked: %0d read, %0d write, %0d err; errors: %0d",
             read_cnt, write_cnt, err_resp_cnt, error_cnt);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Burst master
  ////////////////////////////////////////////////////////////////////////////

  // Returns 2 ns after the edge where the master saw ack or err
  task automatic await_response();
    do begin
      @(negedge wb_clk_i);
    end while (!(wb_ack_o || wb_err_o));
    @(posedge wb_clk_i);
    #2;
  endtask

  task automatic run_transaction();
    logic [31:0]           r;
    logic                  we;
    logic [2:0]            cti_kind;
    logic [2:0]            last_cti;
    logic [1:0]            bte;
    logic [WORD_ADR_W-1:0] idx;
    logic [AW-1:0]         adr;
    int                    len;
    int                    stop_at;
    draw(1, r);
    we = r[0];
    draw(2, r);
    case (r[1:0])
      2'd0: cti_kind = CTI_CLASSIC;
      2'd1: cti_kind = CTI_CONST;
      default: cti_kind = CTI_INCR;
    endcase
    draw(2, r);
    bte = r[1:0];
    len = 1;
    if (cti_kind != CTI_CLASSIC) begin
      draw(4, r);
      len = int'(r[3:0]) + 1;
    end
    last_cti = (cti_kind == CTI_CLASSIC) ? CTI_CLASSIC : CTI_EOB;
    draw(4, r);
    if (r[3:0] == 4'd0) begin
      // Past the end of the memory with low bits that alias the written window
      draw(10, r);
      if (r[9]) begin
        idx = r[9:0];
      end else begin
        idx = WORD_ADR_W'(r[5:0]);
      end
      adr = 32'h0000_1000 + {20'd0, idx, 2'b00};
    end else begin
      draw(2, r);
      // Top of the memory for one pick in four
      if (r[1:0] == 2'd3) begin
        idx = 10'd1016;
      end else begin
        idx = '0;
      end
      draw(10, r);
      // Low window so reads often meet written data and the top one crosses the end
      if (idx == 10'd1016) begin
        idx = idx + WORD_ADR_W'(r[2:0]);
      end else if (r[9]) begin
        idx = r[9:0];
      end else begin
        idx = WORD_ADR_W'(r[5:0]);
      end
      adr = {20'd0, idx, 2'b00};
    end
    stop_at = len;
    draw(3, r);
    if ((r[2:0] == 3'd0) && (len > 1)) begin
      // Drop the cycle before the end of burst beat
      draw(4, r);
      stop_at = 1 + int'(r[3:0]) % (len - 1);
    end
    draw(1, r);
    repeat (1 + int'(r[0])) begin
      @(posedge wb_clk_i);
      #2;
    end
    for (int b = 0; b < stop_at; b++) begin
      draw(4, r);
      wb_sel_i = r[3:0];
      draw(32, r);
      wb_dat_i = r;
      wb_adr_i = adr;
      wb_we_i  = we;
      wb_bte_i = bte;
      wb_cti_i = (b == len - 1) ? last_cti : cti_kind;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      await_response();
      adr = next_burst_adr(adr, cti_kind, bte);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_cti_i = CTI_CLASSIC;
  endtask

  initial begin : stimulus
    lfsr_q   = SEED;
    arst_n_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    wb_we_i  = 1'b0;
    wb_cti_i = CTI_CLASSIC;
    wb_bte_i = BTE_LINEAR;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge wb_clk_i);
    #2;
    arst_n_i = 1'b1;
    for (int t = 0; t < N_TRANS; t++) begin
      run_transaction();
    end
    repeat (4) @(posedge wb_clk_i);
    report_counts();
    if (error_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/wb_mem_pkg.sv
src/burst_access_engine.sv
src/beat_fifo.sv
src/wb_beat_responder.sv
src/wb_burst_mem.sv
bench/wb_mem_checker.sv
bench/tb_wb_burst_mem.sv

// ==== Bender.yml ====
package:
  name: wb_burst_mem

sources:
  # Package first, then leaf modules, then the top
  - src/wb_mem_pkg.sv
  - src/burst_access_engine.sv
  - src/beat_fifo.sv
  - src/wb_beat_responder.sv
  - src/wb_burst_mem.sv

  - target: test
    files:
      - bench/wb_mem_checker.sv
      - bench/tb_wb_burst_mem.sv
